// File: design/adc_bus_pkg.sv
// ------------------------------------------------
// ADC bus definitions
// Host bus address layout, register command codes,
// the packed bus request and the controller ID
// ------------------------------------------------

package adc_bus_pkg;

  localparam int NUM_CH = 8;             // ADC channels served
  localparam logic [15:0] ADC_ID = 16'h0ADC;  // Returned by an ID_REG read

  // Address layout
  // [18:12] offset | [11:8] channel | [7:4] spare | [3:0] command
  typedef struct packed {
    logic [6:0] offset;                  // Upper part of the range check
    logic [3:0] channel;                 // Channel select for per-channel registers
    logic [3:0] spare;                   // Not decoded
    logic [3:0] cmd;                     // Register code, see reg_cmd_e
  } bus_addr_t;

  // Register codes in the command field
  typedef enum logic [3:0] {
    OVERFLOW = 4'h1,                     // Per-channel publish period (write)
    DIVIDE   = 4'h2,                     // Serial clock divider (write)
    PROGRAM  = 4'h4,                     // Command word for the chip (write)
    SAMPLE   = 4'h7,                     // Published sample (read)
    SEQUENCE = 4'h8,                     // Sequence number (read)
    ID_REG   = 4'h9,                     // Constant ID (read)
    BUSY     = 4'hA,                     // Program frame pending (read)
    LAST     = 4'hB                      // Last executed command (read)
  } reg_cmd_e;

  // One bus cycle as seen by the register block
  typedef struct packed {
    logic        enable;                 // Bus select
    logic        re;                     // Read strobe
    logic        wr;                     // Write strobe
    bus_addr_t   addr;
    logic [15:0] data;                   // Write data
  } bus_req_t;

endpackage

// File: design/adc_frame_pkg.sv
// ------------------------------------------------
// ADC serial frame definitions
// Words, sample layout, capture handoff and the
// one-hot frame FSM encoding
// ------------------------------------------------

package adc_frame_pkg;

  typedef logic [15:0] word_t;           // One serial frame or register word
  typedef logic [2:0]  ch_id_t;          // Channel number carried in a sample

  // Sample as shifted in from the chip, channel on top
  typedef struct packed {
    ch_id_t      ch;
    logic [12:0] value;
  } sample_t;

  // Finished sample handed from the serial port to the rate gate
  typedef struct packed {
    logic    valid;                      // One clk pulse at frame end
    sample_t sample;
  } capture_t;

  // Frame FSM, one-hot
  typedef enum logic [4:0] {
    INIT        = 5'b00001,              // Pick next frame kind
    PROGRAM_ADC = 5'b00010,              // Shift command out
    GET_VALUES  = 5'b00100,              // Shift sample in
    COPY        = 5'b01000,              // Sample frame done
    WRITEBACK   = 5'b10000               // Program frame done
  } frame_state_e;

endpackage

// File: design/adc_bus_regs.sv
// ------------------------------------------------
// ADC bus register block
// Range checks the host address, stores the
// PROGRAM, DIVIDE and OVERFLOW registers on writes
// and returns registered read data
// ------------------------------------------------
`timescale 1ns/1ps

module adc_bus_regs #(
  parameter logic [10:0] MIN_CHANNEL = 11'd0,  // Lowest accepted {offset, channel}
  parameter logic [10:0] MAX_CHANNEL = 11'd1   // Highest accepted {offset, channel}
) (
  input  logic                    clk,
  input  logic                    reset,
  input  adc_bus_pkg::bus_req_t   req,
  input  logic                    busy,
  input  adc_frame_pkg::word_t    last_cmd,
  input  adc_frame_pkg::word_t    samples  [adc_bus_pkg::NUM_CH],
  input  adc_frame_pkg::word_t    seq_nums [adc_bus_pkg::NUM_CH],
  output adc_frame_pkg::word_t    data_out,
  output adc_frame_pkg::word_t    cmd_word,
  output adc_frame_pkg::word_t    clk_div,
  output adc_frame_pkg::word_t    period   [adc_bus_pkg::NUM_CH]
);

  import adc_bus_pkg::*;
  import adc_frame_pkg::*;

  logic [10:0] upper;                    // Offset and channel taken together
  logic        sel;                      // Enabled and in range
  ch_id_t      ch;                       // Per-channel register index

  assign upper = {req.addr.offset, req.addr.channel};
  assign sel   = req.enable && (upper >= MIN_CHANNEL) && (upper <= MAX_CHANNEL);
  assign ch    = req.addr.channel[2:0];  // Range check keeps this inside NUM_CH

  // ------------------------------------------------
  // Write side
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_word <= '0;
      clk_div  <= '0;
      for (int i = 0; i < NUM_CH; i++) begin
        period[i] <= '0;                 // Publish every clock until set
      end
    end else if (sel && req.wr) begin
      case (req.addr.cmd)
        PROGRAM:  cmd_word   <= req.data;  // Picked up by the next INIT
        DIVIDE:   clk_div    <= req.data;
        OVERFLOW: period[ch] <= req.data;
        default: ;                       // Read-only codes ignore writes
      endcase
    end
  end

  // ------------------------------------------------
  // Read side, one clock latency
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else if (sel && req.re) begin
      case (req.addr.cmd)
        SAMPLE:   data_out <= samples[ch];
        SEQUENCE: data_out <= seq_nums[ch];
        ID_REG:   data_out <= ADC_ID;
        BUSY:     data_out <= {15'h0000, busy};
        LAST:     data_out <= last_cmd;
        default:  data_out <= '0;        // Write-only or undefined code
      endcase
    end else begin
      data_out <= '0;                    // Bus idle or out of range
    end
  end

endmodule

// File: design/adc_frame_engine.sv
// ------------------------------------------------
// ADC frame engine
// Decides between program and sample frames,
// counts the 16 bits of a frame and drives the
// serial port control levels
// ------------------------------------------------
`timescale 1ns/1ps

module adc_frame_engine (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  bit_tick,   // Rising serial edge
  input  adc_frame_pkg::word_t  cmd_word,   // Host PROGRAM register
  output logic                  busy,
  output adc_frame_pkg::word_t  last_cmd,
  output logic                  cs_n_next,
  output logic                  shift_en,
  output logic                  load_out,
  output adc_frame_pkg::word_t  out_word,
  output logic                  capture_en
);

  import adc_frame_pkg::*;

  frame_state_e state;
  logic [3:0]   bit_cnt;                 // Bits done in the current frame
  word_t        cur_cmd;                 // Command being executed
  logic         last_bit;

  assign last_bit = (bit_cnt == 4'd15);

  // ------------------------------------------------
  // State and datapath registers
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= INIT;
      bit_cnt  <= '0;
      cur_cmd  <= '0;
      last_cmd <= '0;                    // Matches reset cmd_word, so no program frame
    end else begin
      case (state)
        INIT: begin
          bit_cnt <= '0;
          if (bit_tick) begin            // cs falls on this tick
            cur_cmd <= cmd_word;
            if (cmd_word != last_cmd)
              state <= PROGRAM_ADC;      // New command waiting
            else
              state <= GET_VALUES;
          end
        end

        PROGRAM_ADC: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (last_bit) begin
              last_cmd <= cur_cmd;       // Command fully shifted out
              state    <= WRITEBACK;
            end
          end
        end

        GET_VALUES: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (last_bit)
              state <= COPY;             // Serial port emits the capture here
          end
        end

        // Single clk states, cs already high
        COPY:      state <= INIT;
        WRITEBACK: state <= INIT;

        default:   state <= INIT;
      endcase
    end
  end

  // ------------------------------------------------
  // Control levels for the serial port
  // They describe the bit period after the next tick
  // ------------------------------------------------
  always_comb begin
    cs_n_next = 1'b1;
    case (state)
      INIT:        cs_n_next = 1'b0;     // Every INIT tick opens a frame
      PROGRAM_ADC: cs_n_next = last_bit;
      GET_VALUES:  cs_n_next = last_bit;
      default:     cs_n_next = 1'b1;
    endcase
  end

  assign load_out   = (state == PROGRAM_ADC) && (bit_cnt == 4'd0);  // MSB on first fall
  assign shift_en   = (state == PROGRAM_ADC) && (bit_cnt != 4'd0);
  assign capture_en = (state == GET_VALUES);
  assign out_word   = cur_cmd;

  // Pending new command, or one still going out
  assign busy = (cmd_word != last_cmd) || (state == PROGRAM_ADC);

endmodule

// File: design/adc_serial_phy.sv
// ------------------------------------------------
// ADC serial port
// Divides clk into the serial clock, times chip
// select and holds the in and out shift registers
// ------------------------------------------------
`timescale 1ns/1ps

module adc_serial_phy (
  input  logic                     clk,
  input  logic                     reset,
  input  adc_frame_pkg::word_t     clk_div,    // Half period minus one, in clk
  input  logic                     cs_n_next,
  input  logic                     shift_en,
  input  logic                     load_out,
  input  adc_frame_pkg::word_t     out_word,
  input  logic                     capture_en,
  input  logic                     adc_dout,
  output logic                     sclk,
  output logic                     cs,
  output logic                     adc_din,
  output logic                     bit_tick,
  output adc_frame_pkg::capture_t  capture
);

  import adc_frame_pkg::*;

  word_t div_cnt;
  word_t out_reg;                        // MSB drives adc_din
  word_t in_reg;                         // Bits gathered from adc_dout
  logic  div_hit;
  logic  rise_ev;
  logic  fall_ev;
  logic  frame_end;

  assign div_hit   = (div_cnt >= clk_div);  // Also recovers if clk_div shrinks
  assign rise_ev   = div_hit && !sclk;
  assign fall_ev   = div_hit && sclk;
  assign bit_tick  = rise_ev;
  assign frame_end = rise_ev && capture_en && cs_n_next;  // Last bit of a sample frame

  // Serial clock divider
  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
      sclk    <= 1'b0;
    end else if (div_hit) begin
      div_cnt <= '0;
      sclk    <= ~sclk;
    end else begin
      div_cnt <= div_cnt + 16'd1;
    end
  end

  // Chip select moves with the rising edge
  always_ff @(posedge clk) begin
    if (reset)
      cs <= 1'b1;
    else if (rise_ev)
      cs <= cs_n_next;
  end

  // Out register changes on the falling edge
  always_ff @(posedge clk) begin
    if (reset)
      out_reg <= '0;
    else if (fall_ev) begin
      if (load_out)
        out_reg <= out_word;
      else if (shift_en)
        out_reg <= {out_reg[14:0], 1'b0};
      else
        out_reg <= '0;                   // Keep adc_din low between frames
    end
  end

  assign adc_din = out_reg[15];

  // In register samples on the rising edge
  always_ff @(posedge clk) begin
    if (rise_ev && capture_en)
      in_reg <= {in_reg[14:0], adc_dout};
  end

  always_ff @(posedge clk) begin
    if (reset)
      capture.valid <= 1'b0;
    else
      capture.valid <= frame_end;
    if (frame_end)
      capture.sample <= sample_t'({in_reg[14:0], adc_dout});  // Include the final bit
  end

endmodule

// File: design/adc_rate_gate.sv
// ------------------------------------------------
// ADC rate gate
// Buffers the newest sample per channel and
// publishes it every period+1 clocks with a
// running sequence number
// ------------------------------------------------
`timescale 1ns/1ps

module adc_rate_gate (
  input  logic                     clk,
  input  logic                     reset,
  input  adc_frame_pkg::word_t     period   [adc_bus_pkg::NUM_CH],
  input  adc_frame_pkg::capture_t  capture,
  output adc_frame_pkg::word_t     samples  [adc_bus_pkg::NUM_CH],
  output adc_frame_pkg::word_t     seq_nums [adc_bus_pkg::NUM_CH],
  output logic                     new_sample
);

  import adc_bus_pkg::*;
  import adc_frame_pkg::*;

  sample_t                sample_buf [NUM_CH];  // Newest capture per channel
  word_t                  tick_cnt   [NUM_CH];
  logic [NUM_CH-1:0]      publish;

  // Captures land in the slot their channel bits name
  always_ff @(posedge clk) begin
    if (capture.valid)
      sample_buf[capture.sample.ch] <= capture.sample;  // Overwrites if not yet published
  end

  // ------------------------------------------------
  // Per-channel period counters
  // ------------------------------------------------
  for (genvar i = 0; i < NUM_CH; i++) begin : g_chan
    assign publish[i] = (tick_cnt[i] >= period[i]);  // >= survives a shrinking period

    always_ff @(posedge clk) begin
      if (reset) begin
        tick_cnt[i] <= '0;
        seq_nums[i] <= '0;
      end else if (publish[i]) begin
        tick_cnt[i] <= '0;
        seq_nums[i] <= seq_nums[i] + 16'd1;
      end else begin
        tick_cnt[i] <= tick_cnt[i] + 16'd1;
      end
    end

    always_ff @(posedge clk) begin
      if (publish[i])
        samples[i] <= word_t'(sample_buf[i]);  // Channel bits stay on top
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      new_sample <= 1'b0;
    else
      new_sample <= |publish;            // Same edge as the sample registers
  end

endmodule

// File: design/adc_control.sv
// ------------------------------------------------
// ADC controller top level
// Memory-mapped control of an 8-channel serial
// ADC, joins bus registers, frame engine, serial
// port and rate gate
// ------------------------------------------------
`timescale 1ns/1ps

module adc_control #(
  parameter logic [10:0] MIN_CHANNEL = 11'd0,
  parameter logic [10:0] MAX_CHANNEL = 11'd1
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enable,
  input  logic                  re,
  input  logic                  wr,
  input  logic [18:0]           addr,
  input  adc_frame_pkg::word_t  data_in,
  input  logic                  adc_dout,
  output adc_frame_pkg::word_t  data_out,
  output logic                  new_sample,
  output logic                  cs,
  output logic                  sclk,
  output logic                  adc_din
);

  import adc_bus_pkg::*;
  import adc_frame_pkg::*;

  bus_req_t req;
  word_t    cmd_word;
  word_t    clk_div;
  word_t    last_cmd;
  word_t    out_word;
  word_t    period   [NUM_CH];           // OVERFLOW registers
  word_t    samples  [NUM_CH];
  word_t    seq_nums [NUM_CH];
  capture_t capture;
  logic     busy;
  logic     bit_tick;
  logic     cs_n_next;
  logic     shift_en;
  logic     load_out;
  logic     capture_en;

  // Bus strobes into one request
  assign req = '{enable: enable, re: re, wr: wr, addr: bus_addr_t'(addr), data: data_in};

  adc_bus_regs #(
    .MIN_CHANNEL (MIN_CHANNEL),
    .MAX_CHANNEL (MAX_CHANNEL)
  ) i_bus_regs (
    .clk, .reset, .req, .busy, .last_cmd, .samples, .seq_nums,
    .data_out, .cmd_word, .clk_div, .period
  );

  adc_frame_engine i_frame_engine (
    .clk, .reset, .bit_tick, .cmd_word, .busy, .last_cmd,
    .cs_n_next, .shift_en, .load_out, .out_word, .capture_en
  );

  adc_serial_phy i_serial_phy (
    .clk, .reset, .clk_div, .cs_n_next, .shift_en, .load_out, .out_word,
    .capture_en, .adc_dout, .sclk, .cs, .adc_din, .bit_tick, .capture
  );

  adc_rate_gate i_rate_gate (
    .clk, .reset, .period, .capture, .samples, .seq_nums, .new_sample
  );

endmodule

// File: dv/adc_control_asserts.sv
// ------------------------------------------------
// ADC controller assertions
// Chip select in reset, idle read data and the
// per-channel publish spacing, bound to the top
// ------------------------------------------------
`timescale 1ns/1ps

module adc_control_asserts (
  input logic                  clk,
  input logic                  reset,
  input logic                  cs,
  input logic                  enable,
  input logic                  re,
  input adc_frame_pkg::word_t  data_out,
  input adc_frame_pkg::word_t  period_0,   // OVERFLOW register of channel 0
  input adc_frame_pkg::word_t  period_1,
  input adc_frame_pkg::word_t  seq_0,      // Sequence number of channel 0
  input adc_frame_pkg::word_t  seq_1
);

  int fail_cnt = 0;                      // Failed assertions so far

  // Chip select parks high while in reset
  cs_high_in_reset: assert property (@(posedge clk) reset |=> cs)
    else begin
      fail_cnt++;
      $error("cs low after a reset cycle");
    end

  // No read strobe means zero read data one clock later
  idle_read_zero: assert property (@(posedge clk) disable iff (reset)
    !(enable && re) |=> (data_out == '0))
    else begin
      fail_cnt++;
      $error("data_out nonzero after a cycle without a read");
    end

  // A channel with a nonzero period never publishes two clocks running
  ch0_spacing: assert property (@(posedge clk) disable iff (reset)
    ((seq_0 != $past(seq_0)) && (period_0 != '0)) |=> $stable(seq_0))
    else begin
      fail_cnt++;
      $error("channel 0 published on consecutive clocks");
    end

  ch1_spacing: assert property (@(posedge clk) disable iff (reset)
    ((seq_1 != $past(seq_1)) && (period_1 != '0)) |=> $stable(seq_1))
    else begin
      fail_cnt++;
      $error("channel 1 published on consecutive clocks");
    end

endmodule

bind adc_control adc_control_asserts i_asserts (
  .clk(clk), .reset(reset), .cs(cs), .enable(enable), .re(re), .data_out(data_out),
  .period_0(period[0]), .period_1(period[1]), .seq_0(seq_nums[0]), .seq_1(seq_nums[1])
);

// File: dv/adc_control_tb.sv
// ------------------------------------------------
// ADC controller testbench
// Serial ADC model, random bus traffic and checks
// of registers, frames, divider and publish rate
// ------------------------------------------------
`timescale 1ns/1ps

module adc_control_tb;

  import adc_bus_pkg::*;
  import adc_frame_pkg::*;

  localparam int LIMIT = 20000;          // Cycles any single wait may take

  logic        clk = 1'b0;
  logic        reset;
  logic        enable;
  logic        re;
  logic        wr;
  logic [18:0] addr;
  word_t       data_in;
  logic        adc_dout;
  word_t       data_out;
  logic        new_sample;
  logic        cs;
  logic        sclk;
  logic        adc_din;
  int          word_errs = 0;
  int          bit_errs  = 0;
  int          wait_errs = 0;
  logic [12:0] chan_val [NUM_CH];        // Fixed value the model sends per channel
  int          sent_cnt [NUM_CH];        // Sample frames sent per channel
  int          frame_cnt = 0;
  word_t       last_frame;               // adc_din bits of the newest frame
  word_t       prev_cmd = '0;            // Matches the reset command
  word_t       rd;
  word_t       rd2;
  word_t       val;
  int          p;
  int          k;

  adc_control i_dut (
    .clk, .reset, .enable, .re, .wr, .addr, .data_in, .adc_dout,
    .data_out, .new_sample, .cs, .sclk, .adc_din
  );

  always #20 clk = ~clk;                 // 40 ns period

  // ------------------------------------------------
  // Compare and bus helpers
  // ------------------------------------------------
  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      word_errs++;
      $display("ERROR at %0t: %s = 0x%04h, expected 0x%04h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    wait_errs++;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  task automatic tick();                 // Inputs move 2 ns after the edge
    @(posedge clk);
    #2;
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  function automatic logic [18:0] make_addr(input logic [6:0] offset, input logic [3:0] ch,
                                            input reg_cmd_e cmd);
    bus_addr_t a;
    a.offset  = offset;
    a.channel = ch;
    a.spare   = 4'h0;
    a.cmd     = cmd;
    return a;
  endfunction

  task automatic bus_write(input logic [6:0] offset, input logic [3:0] ch,
                           input reg_cmd_e cmd, input word_t data);
    tick();
    enable  = 1'b1;
    wr      = 1'b1;
    addr    = make_addr(offset, ch, cmd);
    data_in = data;
    tick();                              // Taken on this edge
    enable  = 1'b0;
    wr      = 1'b0;
  endtask

  task automatic bus_read(input logic [6:0] offset, input logic [3:0] ch,
                          input reg_cmd_e cmd, output word_t data);
    tick();
    enable = 1'b1;
    re     = 1'b1;
    addr   = make_addr(offset, ch, cmd);
    tick();                              // data_out valid one clock later
    data   = data_out;
    enable = 1'b0;
    re     = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    int start;
    start = frame_cnt;
    for (int i = 0; i < LIMIT && frame_cnt < start + n; i++) tick();
    if (frame_cnt < start + n) report_timeout("serial frames");
  endtask

  // Half periods measured from whole clocks between sclk toggles
  task automatic measure_half_periods(input word_t div);
    int   run;
    int   toggles;
    logic last;
    run     = 0;
    toggles = 0;
    last    = sclk;
    for (int i = 0; i < LIMIT && toggles < 6; i++) begin
      tick();
      run++;
      if (sclk != last) begin
        if (toggles >= 2)                // Earlier ones may be cut by the divider write
          check_word("sclk half period", word_t'(run), div + 16'd1);
        toggles++;
        run  = 0;
        last = sclk;
      end
    end
    if (toggles < 6) report_timeout("sclk toggles");
  endtask

  // ------------------------------------------------
  // Serial ADC model
  // ------------------------------------------------
  initial begin : adc_model
    logic   prev_sclk;
    logic   prev_cs;
    word_t  tx_word;
    word_t  rx_word;
    ch_id_t tx_ch;
    int     rise_cnt;
    adc_dout   = 1'b0;
    prev_sclk  = 1'b0;
    prev_cs    = 1'b1;
    tx_word    = '0;
    rx_word    = '0;
    tx_ch      = '0;
    rise_cnt   = 0;
    last_frame = '0;
    foreach (sent_cnt[i]) sent_cnt[i] = 0;
    forever begin
      tick();
      if (!reset) begin
        if (sclk && !prev_sclk && !prev_cs) begin  // Chip samples adc_din here
          rx_word = {rx_word[14:0], adc_din};
          rise_cnt++;
        end
        if (!cs && prev_cs) begin        // Frame opens, pick a channel
          tx_ch    = ch_id_t'($urandom_range(NUM_CH - 1, 0));
          tx_word  = {tx_ch, chan_val[tx_ch]};
          rx_word  = '0;
          rise_cnt = 0;
        end
        if (cs && !prev_cs) begin        // Frame closes
          check_word("frame length", word_t'(rise_cnt), 16'd16);
          last_frame = rx_word;
          frame_cnt++;
          if (rx_word == '0) sent_cnt[tx_ch]++;  // Program frames carry a nonzero word
        end
        if (!sclk && prev_sclk && !cs) begin     // Next bit after the falling edge
          adc_dout = tx_word[15];
          tx_word  = {tx_word[14:0], 1'b0};
        end
      end
      prev_sclk = sclk;
      prev_cs   = cs;
    end
  end

  // ------------------------------------------------
  // Stimulus and checks
  // ------------------------------------------------
  initial begin
    void'($urandom(32'h2c64_e601));
    reset   = 1'b1;
    enable  = 1'b0;
    re      = 1'b0;
    wr      = 1'b0;
    addr    = '0;
    data_in = '0;
    foreach (chan_val[i]) chan_val[i] = 13'($urandom);
    idle(16);
    check_bit("cs", cs, 1'b1);
    check_bit("sclk", sclk, 1'b0);
    check_bit("new_sample", new_sample, 1'b0);
    check_bit("adc_din", adc_din, 1'b0);
    check_word("data_out", data_out, 16'h0000);
    reset = 1'b0;

    // ID register and out of range reads
    bus_read(7'd0, 4'd0, ID_REG, rd);
    check_word("data_out", rd, 16'h0ADC);
    bus_read(7'd0, 4'd1, ID_REG, rd);
    check_word("data_out", rd, 16'h0ADC);
    repeat (6) begin
      bus_read(7'($urandom), 4'($urandom_range(15, 2)), ID_REG, rd);
      check_word("data_out", rd, 16'h0000);
      bus_read(7'($urandom_range(127, 1)), 4'd0, SAMPLE, rd);
      check_word("data_out", rd, 16'h0000);
    end

    // Samples of channels 0 and 1 with the channel on top
    for (int i = 0; i < LIMIT && (sent_cnt[0] == 0 || sent_cnt[1] == 0); i++) tick();
    if (sent_cnt[0] == 0 || sent_cnt[1] == 0) report_timeout("samples of channels 0 and 1");
    idle(8);
    for (int c = 0; c < 2; c++) begin
      bus_read(7'd0, 4'(c), SAMPLE, rd);
      check_word("data_out", rd, {ch_id_t'(c), chan_val[c]});
    end

    // Program frames
    repeat (3) begin
      val = word_t'($urandom) | 16'h0001;
      if (val == prev_cmd) val = val ^ 16'h8000;
      bus_write(7'd0, 4'd0, PROGRAM, val);
      bus_read(7'd0, 4'd0, BUSY, rd);
      check_word("data_out", rd, 16'h0001);
      for (int i = 0; i < LIMIT && rd != 16'h0000; i++) bus_read(7'd0, 4'd0, BUSY, rd);
      if (rd != 16'h0000) report_timeout("busy to fall");
      idle(2);
      check_word("adc_din frame", last_frame, val);
      bus_read(7'd0, 4'd1, LAST, rd);
      check_word("data_out", rd, val);
      prev_cmd = val;
    end

    // Sequence step over whole publish periods
    for (int n = 0; n < 4; n++) begin
      p = $urandom_range(9, 2);
      k = $urandom_range(4, 1);
      bus_write(7'd0, 4'(n % 2), OVERFLOW, word_t'(p));
      idle(p + 2);
      bus_read(7'd0, 4'(n % 2), SEQUENCE, rd);
      idle(k * (p + 1) - 2);             // Read requests k*(P+1) clocks apart
      bus_read(7'd0, 4'(n % 2), SEQUENCE, rd2);
      check_word("sequence step", rd2 - rd, word_t'(k));
      check_bit("new_sample", new_sample, 1'b1);  // Channels 2 to 7 keep period 0
    end

    // Divider and frame length
    repeat (4) begin
      val = word_t'($urandom_range(3, 0));
      bus_write(7'd0, 4'd0, DIVIDE, val);
      measure_half_periods(val);
      wait_frames(2);
    end

    $display("Errors: %0d value, %0d bit, %0d timeout, %0d assertion",
             word_errs, bit_errs, wait_errs, i_dut.i_asserts.fail_cnt);
    if (word_errs + bit_errs + wait_errs + i_dut.i_asserts.fail_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// File: filelist.f
design/adc_bus_pkg.sv
design/adc_frame_pkg.sv
design/adc_bus_regs.sv
design/adc_frame_engine.sv
design/adc_serial_phy.sv
design/adc_rate_gate.sv
design/adc_control.sv
dv/adc_control_asserts.sv
dv/adc_control_tb.sv

// File: Makefile
# Verilator flow for the ADC controller testbench

TOP := adc_control_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o $(TOP)

# Passes only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
